//--- core_pkg.sv
package core_pkg;

    localparam int xlen  = 32;
    localparam int cnt_w = 64;

    localparam logic [xlen-1:0] insn_nop = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b    // lui
    } alu_op_e;

    typedef enum logic {
        src_rs1,
        src_pc
    } src_a_e;

    typedef enum logic [2:0] {
        csr_none,
        csr_cycle,
        csr_cycleh,
        csr_instret,
        csr_instreth
    } csr_sel_e;

    // read-only counter csrs
    localparam logic [11:0] csr_addr_cycle    = 12'hC00;
    localparam logic [11:0] csr_addr_cycleh   = 12'hC80;
    localparam logic [11:0] csr_addr_instret  = 12'hC02;
    localparam logic [11:0] csr_addr_instreth = 12'hC82;

endpackage : core_pkg

//--- exec_unit.sv
module exec_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      ex_valid_i,
    output logic                      ex_ready_o,
    input  core_pkg::alu_op_e          ex_alu_op_i,
    input  core_pkg::src_a_e           ex_src_a_i,
    input  logic                      ex_use_imm_i,
    input  logic                      ex_we_i,
    input  logic                      ex_branch_i,
    input  logic                      ex_jump_i,
    input  logic                      ex_jalr_i,
    input  logic                      ex_illegal_i,
    input  logic [2:0]                ex_funct3_i,
    input  core_pkg::csr_sel_e         ex_csr_sel_i,
    input  logic [4:0]                ex_rd_i,
    input  logic [core_pkg::xlen-1:0]  ex_imm_i,
    input  logic [core_pkg::xlen-1:0]  ex_pc_i,
    input  logic [core_pkg::xlen-1:0]  ex_insn_i,
    input  logic [core_pkg::xlen-1:0]  ex_rs1_val_i,
    input  logic [core_pkg::xlen-1:0]  ex_rs2_val_i,
    input  logic [core_pkg::cnt_w-1:0] ex_cycle_i,
    input  logic [core_pkg::cnt_w-1:0] ex_instret_i,
    output logic                      res_valid_o,
    input  logic                      res_ready_i,
    output logic [4:0]                res_rd_o,
    output logic                      res_we_o,
    output logic [core_pkg::xlen-1:0]  res_data_o,
    output logic                      res_taken_o,
    output logic [core_pkg::xlen-1:0]  res_target_o,
    output logic                      res_illegal_o,
    output logic [core_pkg::xlen-1:0]  res_pc_o
);
    import core_pkg::*;

    logic [xlen-1:0] op_a, op_b, alu_res;
    logic [xlen-1:0] pc_plus4, pc_imm, jalr_tgt;
    logic [xlen-1:0] csr_val, data, target;
    logic            cond, taken, accept;

    assign ex_ready_o = !res_valid_o || res_ready_i;
    assign accept     = ex_valid_i && ex_ready_o;

    assign op_a = (ex_src_a_i == src_pc) ? ex_pc_i : ex_rs1_val_i;
    assign op_b = ex_use_imm_i ? ex_imm_i : ex_rs2_val_i;

    always_comb begin
        case (ex_alu_op_i)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sll:  alu_res = op_a << op_b[4:0];
            alu_slt:  alu_res = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_res = xlen'(op_a < op_b);
            alu_xor:  alu_res = op_a ^ op_b;
            alu_srl:  alu_res = op_a >> op_b[4:0];
            alu_sra:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_res = op_a | op_b;
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_b; // pass b
        endcase
    end

    always_comb begin
        case (ex_funct3_i)
            3'b000:  cond = ex_rs1_val_i == ex_rs2_val_i;
            3'b001:  cond = ex_rs1_val_i != ex_rs2_val_i;
            3'b100:  cond = $signed(ex_rs1_val_i) < $signed(ex_rs2_val_i);
            3'b101:  cond = $signed(ex_rs1_val_i) >= $signed(ex_rs2_val_i);
            3'b110:  cond = ex_rs1_val_i < ex_rs2_val_i;
            3'b111:  cond = ex_rs1_val_i >= ex_rs2_val_i;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_csr_sel_i)
            csr_cycle:    csr_val = ex_cycle_i[31:0];
            csr_cycleh:   csr_val = ex_cycle_i[63:32];
            csr_instret:  csr_val = ex_instret_i[31:0];
            csr_instreth: csr_val = ex_instret_i[63:32];
            default:      csr_val = '0;
        endcase
    end

    assign pc_plus4 = ex_pc_i + xlen'(4);
    assign pc_imm   = ex_pc_i + ex_imm_i;
    assign jalr_tgt = (ex_rs1_val_i + ex_imm_i) & ~xlen'(1);

    assign taken  = ex_jump_i || (ex_branch_i && cond);
    assign target = ex_jalr_i ? jalr_tgt : (ex_jump_i || ex_branch_i) ? pc_imm : '0;
    assign data   = ex_jump_i ? pc_plus4 : (ex_csr_sel_i != csr_none) ? csr_val : alu_res;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            res_valid_o <= 1'b0;
        else if (ex_ready_o)
            res_valid_o <= ex_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_rd_o      <= ex_rd_i;
            res_we_o      <= ex_we_i;
            res_data_o    <= data;
            res_taken_o   <= taken;
            res_target_o  <= target;
            res_illegal_o <= ex_illegal_i;
            res_pc_o      <= ex_pc_i;
        end
    end

    res_valid_known_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(res_valid_o))
        else $error("res_valid_o unknown after reset");

    // rd of a nop is x0, so the decoder must have dropped its write
    nop_no_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
        ex_valid_i && ex_insn_i == insn_nop |-> !ex_we_i)
        else $error("nop reached execute with write enable set");

endmodule : exec_unit

//--- id_ex_reg.sv
module id_ex_reg (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      dec_valid_i,
    output logic                      dec_ready_o,
    input  core_pkg::alu_op_e          dec_alu_op_i,
    input  core_pkg::src_a_e           dec_src_a_i,
    input  logic                      dec_use_imm_i,
    input  logic                      dec_we_i,
    input  logic                      dec_branch_i,
    input  logic                      dec_jump_i,
    input  logic                      dec_jalr_i,
    input  logic                      dec_illegal_i,
    input  logic [2:0]                dec_funct3_i,
    input  core_pkg::csr_sel_e         dec_csr_sel_i,
    input  logic [4:0]                dec_rd_i,
    input  logic [core_pkg::xlen-1:0]  dec_imm_i,
    input  logic [core_pkg::xlen-1:0]  dec_pc_i,
    input  logic [core_pkg::xlen-1:0]  dec_insn_i,
    input  logic [core_pkg::xlen-1:0]  dec_rs1_val_i,
    input  logic [core_pkg::xlen-1:0]  dec_rs2_val_i,
    output logic                      ex_valid_o,
    input  logic                      ex_ready_i,
    output core_pkg::alu_op_e          ex_alu_op_o,
    output core_pkg::src_a_e           ex_src_a_o,
    output logic                      ex_use_imm_o,
    output logic                      ex_we_o,
    output logic                      ex_branch_o,
    output logic                      ex_jump_o,
    output logic                      ex_jalr_o,
    output logic                      ex_illegal_o,
    output logic [2:0]                ex_funct3_o,
    output core_pkg::csr_sel_e         ex_csr_sel_o,
    output logic [4:0]                ex_rd_o,
    output logic [core_pkg::xlen-1:0]  ex_imm_o,
    output logic [core_pkg::xlen-1:0]  ex_pc_o,
    output logic [core_pkg::xlen-1:0]  ex_insn_o,
    output logic [core_pkg::xlen-1:0]  ex_rs1_val_o,
    output logic [core_pkg::xlen-1:0]  ex_rs2_val_o,
    output logic [core_pkg::cnt_w-1:0] ex_cycle_o,
    output logic [core_pkg::cnt_w-1:0] ex_instret_o
);
    import core_pkg::*;

    logic [cnt_w-1:0] cycle_q;
    logic [cnt_w-1:0] instret_q;
    logic             accept;

    assign dec_ready_o = !ex_valid_o || ex_ready_i;
    assign accept      = dec_valid_i && dec_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            cycle_q <= '1; // wraps to zero on the first live cycle
        else
            cycle_q <= cycle_q + 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            instret_q <= '0;
        else if (accept && dec_insn_i != insn_nop)
            instret_q <= instret_q + 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || (dec_ready_o && !dec_valid_i)) begin // reset or bubble
            ex_valid_o   <= 1'b0;
            ex_alu_op_o  <= alu_add;
            ex_src_a_o   <= src_rs1;
            ex_use_imm_o <= 1'b0;
            ex_we_o      <= 1'b0;
            ex_branch_o  <= 1'b0;
            ex_jump_o    <= 1'b0;
            ex_jalr_o    <= 1'b0;
            ex_illegal_o <= 1'b0;
            ex_funct3_o  <= 3'd0;
            ex_csr_sel_o <= csr_none;
            ex_rd_o      <= 5'd0;
            ex_imm_o     <= '0;
            ex_pc_o      <= '0;
            ex_insn_o    <= insn_nop;
            ex_rs1_val_o <= '0;
            ex_rs2_val_o <= '0;
            ex_cycle_o   <= '0;
            ex_instret_o <= '0;
        end else if (dec_ready_o) begin
            ex_valid_o   <= 1'b1;
            ex_alu_op_o  <= dec_alu_op_i;
            ex_src_a_o   <= dec_src_a_i;
            ex_use_imm_o <= dec_use_imm_i;
            ex_we_o      <= dec_we_i;
            ex_branch_o  <= dec_branch_i;
            ex_jump_o    <= dec_jump_i;
            ex_jalr_o    <= dec_jalr_i;
            ex_illegal_o <= dec_illegal_i;
            ex_funct3_o  <= dec_funct3_i;
            ex_csr_sel_o <= dec_csr_sel_i;
            ex_rd_o      <= dec_rd_i;
            ex_imm_o     <= dec_imm_i;
            ex_pc_o      <= dec_pc_i;
            ex_insn_o    <= dec_insn_i;
            ex_rs1_val_o <= dec_rs1_val_i;
            ex_rs2_val_o <= dec_rs2_val_i;
            ex_cycle_o   <= cycle_q;   // snapshot before increment
            ex_instret_o <= instret_q;
        end
    end

    instret_mono_a: assert property (@(posedge clk_i) disable iff (rst_i)
        instret_q >= $past(instret_q))
        else $error("retired counter went backwards");

endmodule : id_ex_reg

//--- insn_decoder.sv
module insn_decoder (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  logic [core_pkg::xlen-1:0] in_insn_i,
    input  logic [core_pkg::xlen-1:0] in_pc_i,
    input  logic [core_pkg::xlen-1:0] in_rs1_val_i,
    input  logic [core_pkg::xlen-1:0] in_rs2_val_i,
    output logic                     dec_valid_o,
    input  logic                     dec_ready_i,
    output core_pkg::alu_op_e         dec_alu_op_o,
    output core_pkg::src_a_e          dec_src_a_o,
    output logic                     dec_use_imm_o,
    output logic                     dec_we_o,
    output logic                     dec_branch_o,
    output logic                     dec_jump_o,
    output logic                     dec_jalr_o,
    output logic                     dec_illegal_o,
    output logic [2:0]               dec_funct3_o,
    output core_pkg::csr_sel_e        dec_csr_sel_o,
    output logic [4:0]               dec_rd_o,
    output logic [core_pkg::xlen-1:0] dec_imm_o,
    output logic [core_pkg::xlen-1:0] dec_pc_o,
    output logic [core_pkg::xlen-1:0] dec_insn_o,
    output logic [core_pkg::xlen-1:0] dec_rs1_val_o,
    output logic [core_pkg::xlen-1:0] dec_rs2_val_o
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [xlen-1:0] imm_i, imm_b, imm_u, imm_j;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    src_a_e          src_a;
    csr_sel_e        csr_sel;
    logic            use_imm, we, branch, jump, jalr, illegal;
    logic            accept;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = in_insn_i[6:0];
    assign rd     = in_insn_i[11:7];
    assign funct3 = in_insn_i[14:12];
    assign rs1    = in_insn_i[19:15];
    assign funct7 = in_insn_i[31:25];

    assign imm_i = {{20{in_insn_i[31]}}, in_insn_i[31:20]};
    assign imm_b = {{20{in_insn_i[31]}}, in_insn_i[7], in_insn_i[30:25], in_insn_i[11:8], 1'b0};
    assign imm_u = {in_insn_i[31:12], 12'b0};
    assign imm_j = {{12{in_insn_i[31]}}, in_insn_i[19:12], in_insn_i[20], in_insn_i[30:21], 1'b0};

    always_comb begin
        alu_op  = alu_add;
        src_a   = src_rs1;
        csr_sel = csr_none;
        imm     = '0;
        use_imm = 1'b0;
        we      = 1'b0;
        branch  = 1'b0;
        jump    = 1'b0;
        jalr    = 1'b0;
        illegal = 1'b0;
        case (opcode)
            opc_op: begin
                we      = 1'b1;
                alu_op  = alu_from_f3(funct3, funct7[5]);
                illegal = !(funct7 == 7'h00 ||
                            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            opc_op_imm: begin
                we      = 1'b1;
                use_imm = 1'b1;
                imm     = imm_i;
                alu_op  = alu_from_f3(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001)
                    illegal = funct7 != 7'h00;
                else if (funct3 == 3'b101)
                    illegal = funct7 != 7'h00 && funct7 != 7'h20;
            end
            opc_lui: begin
                we      = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = alu_pass_b;
            end
            opc_auipc: begin
                we      = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                src_a   = src_pc;
            end
            opc_jal: begin
                we   = 1'b1;
                jump = 1'b1;
                imm  = imm_j;
            end
            opc_jalr: begin
                we      = 1'b1;
                jump    = 1'b1;
                jalr    = 1'b1;
                imm     = imm_i;
                illegal = funct3 != 3'b000;
            end
            opc_branch: begin
                branch  = 1'b1;
                imm     = imm_b;
                illegal = funct3 == 3'b010 || funct3 == 3'b011;
            end
            opc_system: begin
                we = 1'b1;
                if (funct3 == 3'b010 && rs1 == 5'd0) begin // csrrs rd, csr, x0
                    case (in_insn_i[31:20])
                        csr_addr_cycle:    csr_sel = csr_cycle;
                        csr_addr_cycleh:   csr_sel = csr_cycleh;
                        csr_addr_instret:  csr_sel = csr_instret;
                        csr_addr_instreth: csr_sel = csr_instreth;
                        default:           illegal = 1'b1;
                    endcase
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin // kill every side effect
            branch  = 1'b0;
            jump    = 1'b0;
            jalr    = 1'b0;
            csr_sel = csr_none;
        end
        if (illegal || rd == 5'd0)
            we = 1'b0;
    end

    assign in_ready_o = !dec_valid_o || dec_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            dec_valid_o <= 1'b0;
        else if (in_ready_o)
            dec_valid_o <= in_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_alu_op_o  <= alu_op;
            dec_src_a_o   <= src_a;
            dec_use_imm_o <= use_imm;
            dec_we_o      <= we;
            dec_branch_o  <= branch;
            dec_jump_o    <= jump;
            dec_jalr_o    <= jalr;
            dec_illegal_o <= illegal;
            dec_funct3_o  <= funct3;
            dec_csr_sel_o <= csr_sel;
            dec_rd_o      <= rd;
            dec_imm_o     <= imm;
            dec_pc_o      <= in_pc_i;
            dec_insn_o    <= in_insn_i;
            dec_rs1_val_o <= in_rs1_val_i;
            dec_rs2_val_o <= in_rs2_val_i;
        end
    end

    // held item must not change until id/ex takes it
    dec_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o &&
            $stable({dec_insn_o, dec_pc_o, dec_imm_o, dec_rs1_val_o, dec_rs2_val_o,
                     dec_alu_op_o, dec_we_o, dec_rd_o}))
        else $error("decoder payload changed while stalled");

endmodule : insn_decoder

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_pipe_top \
        -f rv_pipe_top.f -o sim_tb; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0

//--- rv_pipe_top.f
core_pkg.sv
insn_decoder.sv
id_ex_reg.sv
exec_unit.sv
rv_pipe_top.sv
tb_rv_pipe_top.sv

//--- rv_pipe_top.sv
module rv_pipe_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  logic [core_pkg::xlen-1:0] in_insn_i,
    input  logic [core_pkg::xlen-1:0] in_pc_i,
    input  logic [core_pkg::xlen-1:0] in_rs1_val_i,
    input  logic [core_pkg::xlen-1:0] in_rs2_val_i,
    output logic                     res_valid_o,
    input  logic                     res_ready_i,
    output logic [4:0]               res_rd_o,
    output logic                     res_we_o,
    output logic [core_pkg::xlen-1:0] res_data_o,
    output logic                     res_taken_o,
    output logic [core_pkg::xlen-1:0] res_target_o,
    output logic                     res_illegal_o,
    output logic [core_pkg::xlen-1:0] res_pc_o
);
    import core_pkg::*;

    // decoder -> id/ex
    logic            dec_valid, dec_ready;
    alu_op_e         dec_alu_op;
    src_a_e          dec_src_a;
    csr_sel_e        dec_csr_sel;
    logic            dec_use_imm, dec_we, dec_branch, dec_jump, dec_jalr, dec_illegal;
    logic [2:0]      dec_funct3;
    logic [4:0]      dec_rd;
    logic [xlen-1:0] dec_imm, dec_pc, dec_insn, dec_rs1_val, dec_rs2_val;

    // id/ex -> execute
    logic             ex_valid, ex_ready;
    alu_op_e          ex_alu_op;
    src_a_e           ex_src_a;
    csr_sel_e         ex_csr_sel;
    logic             ex_use_imm, ex_we, ex_branch, ex_jump, ex_jalr, ex_illegal;
    logic [2:0]       ex_funct3;
    logic [4:0]       ex_rd;
    logic [xlen-1:0]  ex_imm, ex_pc, ex_insn, ex_rs1_val, ex_rs2_val;
    logic [cnt_w-1:0] ex_cycle, ex_instret;

    insn_decoder u_dec (
        .clk_i(clk_i), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_insn_i(in_insn_i),
        .in_pc_i(in_pc_i), .in_rs1_val_i(in_rs1_val_i), .in_rs2_val_i(in_rs2_val_i),
        .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_alu_op_o(dec_alu_op),
        .dec_src_a_o(dec_src_a), .dec_use_imm_o(dec_use_imm), .dec_we_o(dec_we),
        .dec_branch_o(dec_branch), .dec_jump_o(dec_jump), .dec_jalr_o(dec_jalr),
        .dec_illegal_o(dec_illegal), .dec_funct3_o(dec_funct3), .dec_csr_sel_o(dec_csr_sel),
        .dec_rd_o(dec_rd), .dec_imm_o(dec_imm), .dec_pc_o(dec_pc), .dec_insn_o(dec_insn),
        .dec_rs1_val_o(dec_rs1_val), .dec_rs2_val_o(dec_rs2_val)
    );

    id_ex_reg u_id_ex (
        .clk_i(clk_i), .rst_i(rst_i),
        .dec_valid_i(dec_valid), .dec_ready_o(dec_ready), .dec_alu_op_i(dec_alu_op),
        .dec_src_a_i(dec_src_a), .dec_use_imm_i(dec_use_imm), .dec_we_i(dec_we),
        .dec_branch_i(dec_branch), .dec_jump_i(dec_jump), .dec_jalr_i(dec_jalr),
        .dec_illegal_i(dec_illegal), .dec_funct3_i(dec_funct3), .dec_csr_sel_i(dec_csr_sel),
        .dec_rd_i(dec_rd), .dec_imm_i(dec_imm), .dec_pc_i(dec_pc), .dec_insn_i(dec_insn),
        .dec_rs1_val_i(dec_rs1_val), .dec_rs2_val_i(dec_rs2_val),
        .ex_valid_o(ex_valid), .ex_ready_i(ex_ready), .ex_alu_op_o(ex_alu_op),
        .ex_src_a_o(ex_src_a), .ex_use_imm_o(ex_use_imm), .ex_we_o(ex_we),
        .ex_branch_o(ex_branch), .ex_jump_o(ex_jump), .ex_jalr_o(ex_jalr),
        .ex_illegal_o(ex_illegal), .ex_funct3_o(ex_funct3), .ex_csr_sel_o(ex_csr_sel),
        .ex_rd_o(ex_rd), .ex_imm_o(ex_imm), .ex_pc_o(ex_pc), .ex_insn_o(ex_insn),
        .ex_rs1_val_o(ex_rs1_val), .ex_rs2_val_o(ex_rs2_val),
        .ex_cycle_o(ex_cycle), .ex_instret_o(ex_instret)
    );

    exec_unit u_exec (
        .clk_i(clk_i), .rst_i(rst_i),
        .ex_valid_i(ex_valid), .ex_ready_o(ex_ready), .ex_alu_op_i(ex_alu_op),
        .ex_src_a_i(ex_src_a), .ex_use_imm_i(ex_use_imm), .ex_we_i(ex_we),
        .ex_branch_i(ex_branch), .ex_jump_i(ex_jump), .ex_jalr_i(ex_jalr),
        .ex_illegal_i(ex_illegal), .ex_funct3_i(ex_funct3), .ex_csr_sel_i(ex_csr_sel),
        .ex_rd_i(ex_rd), .ex_imm_i(ex_imm), .ex_pc_i(ex_pc), .ex_insn_i(ex_insn),
        .ex_rs1_val_i(ex_rs1_val), .ex_rs2_val_i(ex_rs2_val),
        .ex_cycle_i(ex_cycle), .ex_instret_i(ex_instret),
        .res_valid_o(res_valid_o), .res_ready_i(res_ready_i), .res_rd_o(res_rd_o),
        .res_we_o(res_we_o), .res_data_o(res_data_o), .res_taken_o(res_taken_o),
        .res_target_o(res_target_o), .res_illegal_o(res_illegal_o), .res_pc_o(res_pc_o)
    );

endmodule : rv_pipe_top

//--- rv_pipe_trace.txt
# I insn pc rs1_val rs2_val          (hex)
# E rd we data taken target illegal  (hex, data X = rdcycle read, data - = not compared)
I 003100B3 00000100 11111111 22222222
E 01 1 33333333 0 00000000 0
I 40628233 00000104 00000005 00000007
E 04 1 FFFFFFFE 0 00000000 0
I 009423B3 00000108 FFFFFFFF 00000001
E 07 1 00000001 0 00000000 0
I 00943533 0000010C FFFFFFFF 00000001
E 0A 1 00000000 0 00000000 0
I 40D655B3 00000110 80000000 00000024
E 0B 1 F8000000 0 00000000 0
I 40415193 00000114 F0000000 00000000
E 03 1 FF000000 0 00000000 0
I FFF30293 00000118 00000010 00000000
E 05 1 0000000F 0 00000000 0
I 0FF0C013 0000011C 000000F0 00000000
E 00 0 0000000F 0 00000000 0
I ABCDE4B7 00000120 00000000 00000000
E 09 1 ABCDE000 0 00000000 0
I 00001517 00000124 00000000 00000000
E 0A 1 00001124 0 00000000 0
I 00000013 00000128 00000000 00000000
E 00 0 00000000 0 00000000 0
I C02025F3 0000012C 00000000 00000000
E 0B 1 0000000A 0 00000000 0
I C8202673 00000130 00000000 00000000
E 0C 1 00000000 0 00000000 0
I C00026F3 00000134 00000000 00000000
E 0D 1 X 0 00000000 0
I 00208863 00000138 00000005 00000005
E 10 0 - 1 00000148 0
I FE208CE3 0000013C 00000005 00000006
E 19 0 - 0 00000134 0
I 00209863 00000140 00000005 00000006
E 10 0 - 1 00000150 0
I FE209CE3 00000144 00000005 00000005
E 19 0 - 0 0000013C 0
I 0020C863 00000148 FFFFFFFE 00000001
E 10 0 - 1 00000158 0
I FE20CCE3 0000014C 00000001 FFFFFFFE
E 19 0 - 0 00000144 0
I 0020D863 00000150 00000001 FFFFFFFE
E 10 0 - 1 00000160 0
I FE20DCE3 00000154 FFFFFFFE 00000001
E 19 0 - 0 0000014C 0
I 0020E863 00000158 00000001 FFFFFFFE
E 10 0 - 1 00000168 0
I FE20ECE3 0000015C FFFFFFFE 00000001
E 19 0 - 0 00000154 0
I 0020F863 00000160 FFFFFFFE 00000001
E 10 0 - 1 00000170 0
I FE20FCE3 00000164 00000001 FFFFFFFE
E 19 0 - 0 0000015C 0
I 020000EF 00000168 00000000 00000000
E 01 1 0000016C 1 00000188 0
I 003302E7 0000016C 00001000 00000000
E 05 1 00000170 1 00001002 0
I 0000050B 00000170 12345678 9ABCDEF0
E 0A 0 - 0 00000000 1
I 00000013 00000174 00000000 00000000
E 00 0 00000000 0 00000000 0
I C02027F3 00000178 00000000 00000000
E 0F 1 0000001C 0 00000000 0
I C0002773 0000017C 00000000 00000000
E 0E 1 X 0 00000000 0

//--- tb_rv_pipe_top.sv
module tb_rv_pipe_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 200;

    logic        clk_i;
    logic        rst_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] in_insn_i;
    logic [31:0] in_pc_i;
    logic [31:0] in_rs1_val_i;
    logic [31:0] in_rs2_val_i;
    logic        res_valid_o;
    logic        res_ready_i;
    logic [4:0]  res_rd_o;
    logic        res_we_o;
    logic [31:0] res_data_o;
    logic        res_taken_o;
    logic [31:0] res_target_o;
    logic        res_illegal_o;
    logic [31:0] res_pc_o;

    // stimulus from the trace
    logic [31:0] insn_q[$];
    logic [31:0] rs1_q[$];
    logic [31:0] rs2_q[$];
    // expected results in input order
    logic [31:0] exp_pc_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_target_q[$];
    logic [4:0]  exp_rd_q[$];
    logic        exp_we_q[$];
    logic        exp_taken_q[$];
    logic        exp_illegal_q[$];
    logic [1:0]  data_mode_q[$]; // 0 exact, 1 cycle read, 2 not compared

    int          n_results;
    logic [31:0] last_cycle;
    bit          seen_cycle;

    rv_pipe_top dut_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_insn_i(in_insn_i),
        .in_pc_i(in_pc_i), .in_rs1_val_i(in_rs1_val_i), .in_rs2_val_i(in_rs2_val_i),
        .res_valid_o(res_valid_o), .res_ready_i(res_ready_i), .res_rd_o(res_rd_o),
        .res_we_o(res_we_o), .res_data_o(res_data_o), .res_taken_o(res_taken_o),
        .res_target_o(res_target_o), .res_illegal_o(res_illegal_o), .res_pc_o(res_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("** Error at %0t: %s expected 0x%h, got 0x%h",
                               $time, name, exp_v, act_v));
    endtask

    function automatic bit is_blank(input byte c);
        return c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d;
    endfunction

    // n-th whitespace separated field of a line
    function automatic string field_of(input string s, input int idx);
        int pos;
        int start;
        int cnt;
        pos = 0;
        cnt = 0;
        while (pos < s.len()) begin
            while (pos < s.len() && is_blank(s.getc(pos)))
                pos++;
            start = pos;
            while (pos < s.len() && !is_blank(s.getc(pos)))
                pos++;
            if (pos > start) begin
                if (cnt == idx)
                    return s.substr(start, pos - 1);
                cnt++;
            end
        end
        return "";
    endfunction

    function automatic logic [31:0] hex_of(input string t);
        return 32'(t.atohex());
    endfunction

    task automatic read_trace();
        int    fd;
        string line;
        string tag;
        string data_s;
        fd = $fopen("rv_pipe_trace.txt", "r");
        if (fd == 0) begin
            fail_run("could not open rv_pipe_trace.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                tag = field_of(line, 0);
                if (tag == "I") begin
                    insn_q.push_back(hex_of(field_of(line, 1)));
                    exp_pc_q.push_back(hex_of(field_of(line, 2)));
                    rs1_q.push_back(hex_of(field_of(line, 3)));
                    rs2_q.push_back(hex_of(field_of(line, 4)));
                end else if (tag == "E") begin
                    data_s = field_of(line, 3);
                    exp_rd_q.push_back(5'(hex_of(field_of(line, 1))));
                    exp_we_q.push_back(hex_of(field_of(line, 2)) != 32'd0);
                    if (data_s == "X")
                        data_mode_q.push_back(2'd1);
                    else if (data_s == "-")
                        data_mode_q.push_back(2'd2);
                    else
                        data_mode_q.push_back(2'd0);
                    exp_data_q.push_back((data_s == "X" || data_s == "-") ? 32'd0
                                                                        : hex_of(data_s));
                    exp_taken_q.push_back(hex_of(field_of(line, 4)) != 32'd0);
                    exp_target_q.push_back(hex_of(field_of(line, 5)));
                    exp_illegal_q.push_back(hex_of(field_of(line, 6)) != 32'd0);
                end
            end
            $fclose(fd);
            if (insn_q.size() == 0 || insn_q.size() != exp_rd_q.size())
                fail_run("trace is empty or its I and E lines do not pair up");
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic drive_inputs();
        int waited;
        bit accepted;
        foreach (insn_q[i]) begin
            if ($urandom_range(3, 0) == 0)
                repeat ($urandom_range(3, 1)) step(); // input gap
            in_valid_i   = 1'b1;
            in_insn_i    = insn_q[i];
            in_pc_i      = exp_pc_q[i];
            in_rs1_val_i = rs1_q[i];
            in_rs2_val_i = rs2_q[i];
            waited   = 0;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk_i);
                accepted = in_ready_o;
                step();
                waited++;
                if (!accepted && waited > timeout_cycles)
                    fail_run($sformatf("timeout: instruction %0d was never accepted", i));
            end
            in_valid_i = 1'b0;
        end
    endtask

    task automatic toggle_ready();
        forever begin
            step();
            res_ready_i = $urandom_range(3, 0) != 0;
        end
    endtask

    task automatic collect_results();
        int waited;
        bit got;
        int k;
        while (n_results < exp_rd_q.size()) begin
            k = n_results;
            waited = 0;
            got = 1'b0;
            while (!got) begin
                @(negedge clk_i);
                got = res_valid_o && res_ready_i;
                waited++;
                if (!got && waited > timeout_cycles)
                    fail_run($sformatf("timeout: result %0d never came out", k));
            end
            check_value("res_pc_o", exp_pc_q[k], res_pc_o); // also proves the order
            check_value("res_rd_o", 32'(exp_rd_q[k]), 32'(res_rd_o));
            check_value("res_we_o", 32'(exp_we_q[k]), 32'(res_we_o));
            check_value("res_taken_o", 32'(exp_taken_q[k]), 32'(res_taken_o));
            check_value("res_target_o", exp_target_q[k], res_target_o);
            check_value("res_illegal_o", 32'(exp_illegal_q[k]), 32'(res_illegal_o));
            if (data_mode_q[k] == 2'd0) begin
                check_value("res_data_o", exp_data_q[k], res_data_o);
            end else if (data_mode_q[k] == 2'd1) begin
                if (seen_cycle)
                    check_value("res_data_o cycle rises", 32'd1,
                                32'(res_data_o > last_cycle));
                last_cycle = res_data_o;
                seen_cycle = 1'b1;
            end
            n_results++;
        end
    endtask

    initial begin
        void'($urandom(27633));
        rst_i        = 1'b1;
        in_valid_i   = 1'b0;
        in_insn_i    = 32'd0;
        in_pc_i      = 32'd0;
        in_rs1_val_i = 32'd0;
        in_rs2_val_i = 32'd0;
        res_ready_i  = 1'b0;
        n_results    = 0;
        last_cycle   = 32'd0;
        seen_cycle   = 1'b0;
        read_trace();
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        check_value("in_ready_o", 32'd1, 32'(in_ready_o));
        check_value("res_valid_o", 32'd0, 32'(res_valid_o));
        step();
        fork
            toggle_ready();
        join_none
        fork
            drive_inputs();
            collect_results();
        join
        // nothing may follow the last result
        repeat (10) begin
            @(negedge clk_i);
            check_value("res_valid_o after last result", 32'd0, 32'(res_valid_o));
        end
        if (n_results != exp_rd_q.size()) begin
            fail_run($sformatf("only %0d of %0d results arrived", n_results,
                               exp_rd_q.size()));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule : tb_rv_pipe_top
